//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_traffic_controller
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the simulation printed the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
verilog/signal_pkg.sv
verilog/lane_capture.sv
verilog/phase_sequencer.sv
verilog/aspect_sequencer.sv
verilog/dwell_timer.sv
verilog/traffic_controller.sv
tb/tb_checker.sv
tb/tb_traffic_controller.sv

//--- tb/tb_checker.sv
// expected lights rebuilt from the dwell tables; test names must fit in NAME_LEN characters
`timescale 1ns/1ps

module tb_checker #(
  parameter int NAME_LEN = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  signal_pkg::count_t    car_main_s,
  input  signal_pkg::count_t    car_main_lt,
  input  signal_pkg::count_t    car_side_s,
  input  signal_pkg::count_t    car_side_lt,
  input  logic                  out_valid,
  input  signal_pkg::light_t    light_main,
  input  signal_pkg::light_t    light_side,
  input  logic [8*NAME_LEN-1:0] test_name,
  input  logic                  test_done,
  output int                    test_count,
  output int                    fail_count,
  output int                    error_count
);

  import signal_pkg::*;

  // one {main, side} entry per busy cycle
  logic [3:0] exp_q[$];
  int         test_errors;
  int         test_cycle;

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  // lane 0..3 in service order
  function automatic dwell_t table_dwell(int lane, count_t c);
    dwell_t d;
    if (lane == 0) begin
      d = (c >= 3'd5) ? DWELL_MAIN_S_LONG : DWELL_MAIN_S_SHORT;
    end else if (lane == 3) begin
      if (c == 3'd7) begin
        d = DWELL_SIDE_LT_7;
      end else if (c >= 3'd5) begin
        d = DWELL_SIDE_LT_5;
      end else if (c >= 3'd3) begin
        d = DWELL_SIDE_LT_3;
      end else begin
        d = DWELL_SIDE_LT_1;
      end
    end else begin
      // main left and side straight share a table
      if (c == 3'd7) begin
        d = DWELL_MID_LONG;
      end else if (c >= 3'd4) begin
        d = DWELL_MID_MED;
      end else begin
        d = DWELL_MID_SHORT;
      end
    end
    return d;
  endfunction

  // opposite head held red
  task automatic push_aspect(int lane, light_t a);
    if (lane < 2) begin
      exp_q.push_back({a, LIGHT_RED});
    end else begin
      exp_q.push_back({LIGHT_RED, a});
    end
  endtask

  // go for the table dwell, then one yellow and one red
  task automatic push_lane(int lane, count_t c);
    dwell_t d;
    light_t go;
    d  = table_dwell(lane, c);
    go = (lane % 2 == 1) ? LIGHT_LEFT : LIGHT_GREEN;
    for (int k = 0; k < int'(d); k++) begin
      push_aspect(lane, go);
    end
    push_aspect(lane, LIGHT_YELLOW);
    push_aspect(lane, LIGHT_RED);
  endtask

  function automatic string light_text(light_t l);
    case (l)
      LIGHT_RED:    return "red";
      LIGHT_YELLOW: return "yellow";
      LIGHT_GREEN:  return "green";
      LIGHT_LEFT:   return "left";
      default:      return "unknown";
    endcase
  endfunction

  // skip the zero padding of short names
  function automatic string name_text(logic [8*NAME_LEN-1:0] n);
    string      s;
    logic [7:0] ch;
    s = "";
    for (int i = NAME_LEN - 1; i >= 0; i--) begin
      ch = n[8*i +: 8];
      if (ch != 8'd0) begin
        s = $sformatf("%s%c", s, ch);
      end
    end
    return s;
  endfunction

  // --------------------------------------------------
  // per-cycle compare, values seen just before the edge
  // --------------------------------------------------
  always @(posedge clk) begin
    logic [3:0] exp_lights;
    logic       exp_valid;
    logic       was_idle;
    if (!rst_n) begin
      exp_q.delete();
      test_errors = 0;
      test_cycle  = 0;
      test_count  = 0;
      fail_count  = 0;
      error_count = 0;
    end else begin
      was_idle = (exp_q.size() == 0);
      if (was_idle) begin
        // idle rest state
        exp_lights = {LIGHT_GREEN, LIGHT_RED};
        exp_valid  = 1'b0;
      end else begin
        exp_lights = exp_q.pop_front();
        exp_valid  = 1'b1;
      end
      test_cycle++;
      if ((out_valid !== exp_valid) || ({light_main, light_side} !== exp_lights)) begin
        test_errors++;
        error_count++;
        $display("Fail %s cycle %0d: expected valid=%0b main=%s side=%s, %s",
                 name_text(test_name), test_cycle, exp_valid,
                 light_text(light_t'(exp_lights[3:2])), light_text(light_t'(exp_lights[1:0])),
                 $sformatf("actual valid=%0b main=%s side=%s", out_valid,
                           light_text(light_main), light_text(light_side)));
      end
      // only an idle controller takes counts
      if ((in_valid === 1'b1) && was_idle) begin
        if (car_main_s != 3'd0) begin
          push_lane(0, car_main_s);
        end
        if (car_main_lt != 3'd0) begin
          push_lane(1, car_main_lt);
        end
        if (car_side_s != 3'd0) begin
          push_lane(2, car_side_s);
        end
        if (car_side_lt != 3'd0) begin
          push_lane(3, car_side_lt);
        end
      end
      if (test_done === 1'b1) begin
        test_count++;
        if (exp_q.size() != 0) begin
          test_errors++;
          error_count++;
          $display("Test %s ended while its light sequence was still running",
                   name_text(test_name));
        end
        if (test_errors == 0) begin
          $display("Pass %s (%0d cycles)", name_text(test_name), test_cycle);
        end else begin
          fail_count++;
          $display("Test %s failed with %0d errors", name_text(test_name), test_errors);
        end
        test_errors = 0;
        test_cycle  = 0;
      end
    end
  end

endmodule

//--- tb/tb_traffic_controller.sv
// table-driven run of the controller; the last rows come from an 8-bit Galois LFSR seeded with 21
`timescale 1ns/1ps

module tb_traffic_controller;

  import signal_pkg::*;

  localparam int NUM_ROWS  = 13;
  localparam int NUM_FIXED = 9;
  localparam int NAME_LEN  = 16;
  // longest busy window is 38 cycles
  localparam int TIMEOUT   = 64;
  localparam int IDLE_WAIT = 4;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  count_t                car_main_s;
  count_t                car_main_lt;
  count_t                car_side_s;
  count_t                car_side_lt;
  logic                  out_valid;
  light_t                light_main;
  light_t                light_side;
  logic [8*NAME_LEN-1:0] test_name;
  logic                  test_done;
  int                    test_count;
  int                    fail_count;
  int                    error_count;

  // stimulus table
  logic [8*NAME_LEN-1:0] row_name [NUM_ROWS];
  count_t                row_cnt  [NUM_ROWS][4];
  logic [7:0]            lfsr;
  logic                  timed_out;

  traffic_controller dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .car_main_s  (car_main_s),
    .car_main_lt (car_main_lt),
    .car_side_s  (car_side_s),
    .car_side_lt (car_side_lt),
    .out_valid   (out_valid),
    .light_main  (light_main),
    .light_side  (light_side)
  );

  tb_checker #(
    .NAME_LEN (NAME_LEN)
  ) chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .car_main_s  (car_main_s),
    .car_main_lt (car_main_lt),
    .car_side_s  (car_side_s),
    .car_side_lt (car_side_lt),
    .out_valid   (out_valid),
    .light_main  (light_main),
    .light_side  (light_side),
    .test_name   (test_name),
    .test_done   (test_done),
    .test_count  (test_count),
    .fail_count  (fail_count),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
  end

  always #2 clk = ~clk;

  // --------------------------------------------------
  // table setup
  // --------------------------------------------------
  // taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(logic [7:0] s);
    logic [7:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 8'hB8;
    end
    return n;
  endfunction

  // one step per bit taken
  task automatic random_count(output count_t c);
    for (int b = 0; b < 3; b++) begin
      c[b] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic set_row(input int r, input logic [8*NAME_LEN-1:0] name,
                         input count_t ms, input count_t ml, input count_t ss, input count_t sl);
    row_name[r]   = name;
    row_cnt[r][0] = ms;
    row_cnt[r][1] = ml;
    row_cnt[r][2] = ss;
    row_cnt[r][3] = sl;
  endtask

  task automatic random_row(input int r, input logic [8*NAME_LEN-1:0] name);
    count_t c;
    row_name[r] = name;
    for (int l = 0; l < 4; l++) begin
      random_count(c);
      row_cnt[r][l] = c;
    end
  endtask

  task automatic fill_table();
    // lanes: main straight, main left, side straight, side left
    set_row(0, "all_zero", 3'd0, 3'd0, 3'd0, 3'd0);
    set_row(1, "main_only", 3'd5, 3'd4, 3'd0, 3'd0);
    set_row(2, "main_s_4", 3'd4, 3'd0, 3'd0, 3'd0);
    set_row(3, "main_lt_3", 3'd0, 3'd3, 3'd0, 3'd0);
    set_row(4, "side_s_7", 3'd0, 3'd0, 3'd7, 3'd0);
    set_row(5, "side_lt_2", 3'd0, 3'd0, 3'd0, 3'd2);
    set_row(6, "all_seven", 3'd7, 3'd7, 3'd7, 3'd7);
    set_row(7, "mixed_a", 3'd5, 3'd2, 3'd6, 3'd3);
    set_row(8, "mixed_b", 3'd4, 3'd4, 3'd3, 3'd6);
    random_row(NUM_FIXED, "random_0");
    random_row(NUM_FIXED + 1, "random_1");
    random_row(NUM_FIXED + 2, "random_2");
    random_row(NUM_FIXED + 3, "random_3");
  endtask

  // level seen just before each edge
  task automatic wait_valid(input logic level, output logic ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && (n < TIMEOUT)) begin
      @(posedge clk);
      ok = (out_valid === level);
      n++;
    end
  endtask

  // --------------------------------------------------
  // stimulus loop
  // --------------------------------------------------
  initial begin
    logic ok;
    logic all_zero;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    car_main_s  = 3'd0;
    car_main_lt = 3'd0;
    car_side_s  = 3'd0;
    car_side_lt = 3'd0;
    test_name   = '0;
    test_done   = 1'b0;
    lfsr        = 8'd21;
    timed_out   = 1'b0;
    fill_table();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; (i < NUM_ROWS) && !timed_out; i++) begin
      all_zero = (row_cnt[i][0] == 3'd0) && (row_cnt[i][1] == 3'd0) &&
                 (row_cnt[i][2] == 3'd0) && (row_cnt[i][3] == 3'd0);
      @(posedge clk);
      test_name   <= row_name[i];
      in_valid    <= 1'b1;
      car_main_s  <= row_cnt[i][0];
      car_main_lt <= row_cnt[i][1];
      car_side_s  <= row_cnt[i][2];
      car_side_lt <= row_cnt[i][3];
      @(posedge clk);
      in_valid <= 1'b0;
      if (all_zero) begin
        repeat (IDLE_WAIT) @(posedge clk);
      end else begin
        wait_valid(1'b1, ok);
        if (ok) begin
          // counts offered mid-sequence must be dropped
          in_valid    <= 1'b1;
          car_main_s  <= ~row_cnt[i][0];
          car_main_lt <= ~row_cnt[i][1];
          car_side_s  <= ~row_cnt[i][2];
          car_side_lt <= ~row_cnt[i][3];
          @(posedge clk);
          in_valid <= 1'b0;
          wait_valid(1'b0, ok);
        end
        if (!ok) begin
          $display("Timeout in row %0d: out_valid did not change within %0d cycles",
                   i, TIMEOUT);
          timed_out = 1'b1;
        end
      end
      if (!timed_out) begin
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
      end
    end
    // let the checker settle its counts
    @(negedge clk);
    $display("Tests %0d, failed %0d, mismatched cycles %0d", test_count, fail_count,
             error_count);
    if (timed_out || (fail_count != 0) || (error_count != 0)) begin
      $display("Finished with errors");
    end else begin
      $display("Finished with no errors");
    end
    $finish;
  end

endmodule

//--- verilog/aspect_sequencer.sv
// go/yellow/red within one phase; phase_start must fall in an idle or red cycle, timer width DWELL_WIDTH
`timescale 1ns/1ps

module aspect_sequencer #(
  parameter int DWELL_WIDTH = signal_pkg::DWELL_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  signal_pkg::phase_t     phase,
  input  logic                   phase_start,
  input  signal_pkg::dwell_t     phase_dwell,
  input  logic                   timer_done,
  output logic                   timer_load,
  output logic [DWELL_WIDTH-1:0] timer_value,
  output logic                   phase_done,
  output signal_pkg::light_t     light_main,
  output signal_pkg::light_t     light_side
);

  import signal_pkg::*;

  aspect_t aspect, aspect_d;
  dwell_t  dwell_m1;
  light_t  head;
  logic    left_phase;

  // load lands on the edge opening the phase
  // so count D-1 gives exactly D go cycles
  assign timer_load  = phase_start;
  assign dwell_m1    = phase_dwell - dwell_t'(1);
  assign timer_value = DWELL_WIDTH'(dwell_m1);

  // --------------------------------------------------
  // aspect FSM
  // --------------------------------------------------
  always_comb begin
    aspect_d = aspect;
    case (aspect)
      ASPECT_GO: begin
        if (timer_done) begin
          aspect_d = ASPECT_YELLOW;
        end
      end
      ASPECT_YELLOW: aspect_d = ASPECT_RED;
      default:       aspect_d = ASPECT_RED;
    endcase
    // new phase restarts go
    if (phase_start) begin
      aspect_d = ASPECT_GO;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      aspect <= ASPECT_RED;
    end else begin
      aspect <= aspect_d;
    end
  end

  // red lasts one cycle, phase moves on after it
  assign phase_done = (aspect == ASPECT_RED) && (phase != PHASE_IDLE);

  // --------------------------------------------------
  // head mapping
  // --------------------------------------------------
  assign left_phase = (phase == PHASE_MAIN_LT) || (phase == PHASE_SIDE_LT);

  always_comb begin
    case (aspect)
      ASPECT_GO:     head = left_phase ? LIGHT_LEFT : LIGHT_GREEN;
      ASPECT_YELLOW: head = LIGHT_YELLOW;
      default:       head = LIGHT_RED;
    endcase
  end

  always_comb begin
    case (phase)
      PHASE_MAIN_S, PHASE_MAIN_LT: begin
        light_main = head;
        light_side = LIGHT_RED;
      end
      PHASE_SIDE_S, PHASE_SIDE_LT: begin
        light_main = LIGHT_RED;
        light_side = head;
      end
      default: begin
        // idle rests on main green
        light_main = LIGHT_GREEN;
        light_side = LIGHT_RED;
      end
    endcase
  end

  // phases never cut into a go or yellow in progress
  a_start_clean: assert property (@(posedge clk) disable iff (!rst_n)
    phase_start |-> (phase == PHASE_IDLE) || (aspect == ASPECT_RED))
    else $error("phase_start outside idle or red");

endmodule

//--- verilog/dwell_timer.sv
// down counter that saturates at zero; a load takes effect on the next edge and must only arrive once done is high
`timescale 1ns/1ps

module dwell_timer #(
  parameter int DWELL_WIDTH = signal_pkg::DWELL_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load,
  input  logic [DWELL_WIDTH-1:0] value,
  output logic                   done
);

  logic [DWELL_WIDTH-1:0] count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= value;
    end else if (!done) begin
      count <= count - DWELL_WIDTH'(1);
    end
  end

  assign done = (count == '0);

  // reload only lands once the previous go count has run out
  a_load_when_done: assert property (@(posedge clk) disable iff (!rst_n)
    load |-> done)
    else $error("timer reloaded while still counting");

endmodule

//--- verilog/lane_capture.sv
// count capture; capture must only be raised while idle, and during it the flags and dwell follow the inputs
`timescale 1ns/1ps

module lane_capture (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                capture,
  input  signal_pkg::count_t  car_main_s,
  input  signal_pkg::count_t  car_main_lt,
  input  signal_pkg::count_t  car_side_s,
  input  signal_pkg::count_t  car_side_lt,
  input  signal_pkg::phase_t  phase,
  output logic [3:0]          lane_nz,
  output signal_pkg::dwell_t  phase_dwell
);

  import signal_pkg::*;

  count_t main_s_q, main_lt_q, side_s_q, side_lt_q;
  // counts as seen this cycle
  count_t main_s_v, main_lt_v, side_s_v, side_lt_v;
  phase_t target;
  count_t target_cnt;
  logic   cur_nz;

  // held counts, payload only
  always_ff @(posedge clk) begin
    if (capture) begin
      main_s_q  <= car_main_s;
      main_lt_q <= car_main_lt;
      side_s_q  <= car_side_s;
      side_lt_q <= car_side_lt;
    end
  end

  // bypass so the first lane is known on the capture edge
  assign main_s_v  = capture ? car_main_s  : main_s_q;
  assign main_lt_v = capture ? car_main_lt : main_lt_q;
  assign side_s_v  = capture ? car_side_s  : side_s_q;
  assign side_lt_v = capture ? car_side_lt : side_lt_q;

  assign lane_nz = {|side_lt_v, |side_s_v, |main_lt_v, |main_s_v};

  // --------------------------------------------------
  // dwell of the lane about to be served
  // --------------------------------------------------
  assign target = next_phase(phase, lane_nz);

  always_comb begin
    case (target)
      PHASE_MAIN_S:  target_cnt = main_s_v;
      PHASE_MAIN_LT: target_cnt = main_lt_v;
      PHASE_SIDE_S:  target_cnt = side_s_v;
      default:       target_cnt = side_lt_v;
    endcase
  end

  // zero when nothing is left to serve
  assign phase_dwell = dwell_for(target, target_cnt);

  // flag of the lane in service
  always_comb begin
    case (phase)
      PHASE_MAIN_S:  cur_nz = lane_nz[0];
      PHASE_MAIN_LT: cur_nz = lane_nz[1];
      PHASE_SIDE_S:  cur_nz = lane_nz[2];
      PHASE_SIDE_LT: cur_nz = lane_nz[3];
      default:       cur_nz = 1'b0;
    endcase
  end

  // sequencer only ever enters a lane with cars, and counts hold while busy
  a_busy_lane_nz: assert property (@(posedge clk) disable iff (!rst_n)
    (phase != PHASE_IDLE) |-> cur_nz)
    else $error("lane in service has a zero count");

endmodule

//--- verilog/phase_sequencer.sv
// master FSM; phase_done must come from the red cycle of the current phase, in_valid is dropped while busy
`timescale 1ns/1ps

module phase_sequencer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  logic [3:0]         lane_nz,
  input  logic               phase_done,
  output signal_pkg::phase_t phase,
  output logic               phase_start,
  output logic               out_valid,
  output logic               accept
);

  import signal_pkg::*;

  phase_t phase_d;
  phase_t next_lane;
  logic   advance;

  // capture only when idle
  assign accept = in_valid && (phase == PHASE_IDLE);

  assign next_lane = next_phase(phase, lane_nz);
  assign advance   = accept || phase_done;

  always_comb begin
    phase_d = phase;
    if (advance) begin
      phase_d = next_lane;
    end
  end

  // --------------------------------------------------
  // state register
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= PHASE_IDLE;
    end else begin
      phase <= phase_d;
    end
  end

  // high in the cycle whose closing edge opens a lane phase
  // all-zero capture leaves next_lane idle so no start
  assign phase_start = advance && (next_lane != PHASE_IDLE);

  assign out_valid = (phase != PHASE_IDLE);

  // red lasts one cycle, so the next phase or idle follows at once
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    phase_done |=> !phase_done)
    else $error("phase_done held for more than one cycle");

endmodule

//--- verilog/signal_pkg.sv
// shared types and dwell tables, whose largest entry (8) needs a dwell width of at least four bits
package signal_pkg;

  localparam int DWELL_WIDTH = 4;

  typedef logic [2:0] count_t;
  typedef logic [DWELL_WIDTH-1:0] dwell_t;

  // encodings follow the signal head wiring
  typedef enum logic [1:0] {
    LIGHT_RED    = 2'b00,
    LIGHT_YELLOW = 2'b01,
    LIGHT_GREEN  = 2'b10,
    LIGHT_LEFT   = 2'b11
  } light_t;

  // lane phases are numbered in service order, idle first
  typedef enum logic [2:0] {
    PHASE_IDLE    = 3'd0,
    PHASE_MAIN_S  = 3'd1,
    PHASE_MAIN_LT = 3'd2,
    PHASE_SIDE_S  = 3'd3,
    PHASE_SIDE_LT = 3'd4
  } phase_t;

  typedef enum logic [1:0] {
    ASPECT_GO,
    ASPECT_YELLOW,
    ASPECT_RED
  } aspect_t;

  // --------------------------------------------------
  // dwell tables
  // --------------------------------------------------
  localparam count_t MAIN_S_THRESH     = 3'd4;
  localparam dwell_t DWELL_MAIN_S_SHORT = 4'd3;
  localparam dwell_t DWELL_MAIN_S_LONG  = 4'd7;
  // shared by main left and side straight
  localparam dwell_t DWELL_MID_SHORT    = 4'd2;
  localparam dwell_t DWELL_MID_MED      = 4'd5;
  localparam dwell_t DWELL_MID_LONG     = 4'd8;
  localparam dwell_t DWELL_SIDE_LT_1    = 4'd1;
  localparam dwell_t DWELL_SIDE_LT_3    = 4'd3;
  localparam dwell_t DWELL_SIDE_LT_5    = 4'd5;
  localparam dwell_t DWELL_SIDE_LT_7    = 4'd7;

  // next lane to serve after cur, lane i maps to phase i+1
  function automatic phase_t next_phase(phase_t cur, logic [3:0] nz);
    phase_t nxt;
    nxt = PHASE_IDLE;
    // downward scan so the lowest later lane wins
    for (int i = 3; i >= 0; i--) begin
      if (nz[i] && (i >= int'(cur))) begin
        nxt = phase_t'(i + 1);
      end
    end
    return nxt;
  endfunction

  // green time for a lane phase given its car count
  function automatic dwell_t dwell_for(phase_t p, count_t c);
    dwell_t d;
    d = '0;
    case (p)
      PHASE_MAIN_S: begin
        d = (c > MAIN_S_THRESH) ? DWELL_MAIN_S_LONG : DWELL_MAIN_S_SHORT;
      end
      PHASE_MAIN_LT, PHASE_SIDE_S: begin
        if (c == 3'd7) begin
          d = DWELL_MID_LONG;
        end else if (c[2]) begin
          d = DWELL_MID_MED;
        end else begin
          d = DWELL_MID_SHORT;
        end
      end
      PHASE_SIDE_LT: begin
        case (c)
          3'd0, 3'd1, 3'd2: d = DWELL_SIDE_LT_1;
          3'd3, 3'd4:       d = DWELL_SIDE_LT_3;
          3'd5, 3'd6:       d = DWELL_SIDE_LT_5;
          default:          d = DWELL_SIDE_LT_7;
        endcase
      end
      default: begin
        d = '0;
      end
    endcase
    return d;
  endfunction

endpackage

//--- verilog/traffic_controller.sv
// four-lane controller top; counts are taken only when idle, out_valid marks the busy window
`timescale 1ns/1ps

module traffic_controller #(
  parameter int DWELL_WIDTH = signal_pkg::DWELL_WIDTH
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  signal_pkg::count_t car_main_s,
  input  signal_pkg::count_t car_main_lt,
  input  signal_pkg::count_t car_side_s,
  input  signal_pkg::count_t car_side_lt,
  output logic               out_valid,
  output signal_pkg::light_t light_main,
  output signal_pkg::light_t light_side
);

  import signal_pkg::*;

  logic                   accept;
  logic [3:0]             lane_nz;
  dwell_t                 phase_dwell;
  phase_t                 phase;
  logic                   phase_start;
  logic                   phase_done;
  logic                   timer_load;
  logic [DWELL_WIDTH-1:0] timer_value;
  logic                   timer_done;

  // --------------------------------------------------
  // capture and master sequencing
  // --------------------------------------------------
  lane_capture u_capture (
    .clk         (clk),
    .rst_n       (rst_n),
    .capture     (accept),
    .car_main_s  (car_main_s),
    .car_main_lt (car_main_lt),
    .car_side_s  (car_side_s),
    .car_side_lt (car_side_lt),
    .phase       (phase),
    .lane_nz     (lane_nz),
    .phase_dwell (phase_dwell)
  );

  phase_sequencer u_phase (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .lane_nz     (lane_nz),
    .phase_done  (phase_done),
    .phase       (phase),
    .phase_start (phase_start),
    .out_valid   (out_valid),
    .accept      (accept)
  );

  // --------------------------------------------------
  // per-phase lights and timer
  // --------------------------------------------------
  aspect_sequencer #(
    .DWELL_WIDTH (DWELL_WIDTH)
  ) u_aspect (
    .clk         (clk),
    .rst_n       (rst_n),
    .phase       (phase),
    .phase_start (phase_start),
    .phase_dwell (phase_dwell),
    .timer_done  (timer_done),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .phase_done  (phase_done),
    .light_main  (light_main),
    .light_side  (light_side)
  );

  dwell_timer #(
    .DWELL_WIDTH (DWELL_WIDTH)
  ) u_timer (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (timer_load),
    .value (timer_value),
    .done  (timer_done)
  );

endmodule
